// ==== ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    // Controller FSM states
    typedef enum logic [4:0] {
        ResetInit,      // Stack pointer written here
        Fetch1,         // Memory read of the instruction
        Fetch2,         // IR load and PC + 4
        Decode,
        AluR,
        WriteRd,
        AluI,
        WriteRt,
        Jr,
        SavePc,
        BranchCalc,     // Branch target into ALUOut
        BranchCompare,
        BranchCommit,
        MemCalc,        // Effective address
        ReadMem,
        LoadWord,
        StoreWord,
        Jump,
        Jal,
        InvalidOp,
        Overflow,
        Exception
    } ctrlState_t;

    // Instruction class after decoding opcode and funct
    typedef enum logic [4:0] {
        ClsAdd,
        ClsSub,
        ClsAnd,
        ClsOr,
        ClsSlt,
        ClsJr,
        ClsAddi,
        ClsAddiu,
        ClsSlti,
        ClsBeq,
        ClsBne,
        ClsBle,
        ClsBgt,
        ClsLw,
        ClsSw,
        ClsJ,
        ClsJal,
        ClsInvalid
    } instrClass_t;

endpackage

`default_nettype wire

// ==== datapathPkg.sv ====
`default_nettype none

package datapathPkg;

    localparam int OpcodeWidth = 6;     // Opcode and funct fields

    // ALU operation codes as the ALU decodes them
    typedef enum logic [4:0] {
        AluLoad    = 5'b00000,   // Pass A
        AluAddOv   = 5'b00001,
        AluSub     = 5'b00010,
        AluAnd     = 5'b00011,
        AluCmp     = 5'b00111,   // Set on less than
        AluOr      = 5'b01000,
        AluAddNoOv = 5'b01011,
        AluNe      = 5'b01110,
        AluEq      = 5'b01111,
        AluLe      = 5'b10000,
        AluGt      = 5'b10001
    } aluOp_t;

    typedef enum logic [2:0] {
        PcJumpTarget   = 3'd0,
        PcAluResult    = 3'd1,
        PcAluOut       = 3'd2,
        PcExceptVector = 3'd3
    } pcSource_t;

    typedef enum logic [2:0] {
        MtrAluOut     = 3'd0,
        MtrMemData    = 3'd1,
        MtrStackInit  = 3'd2,   // Initial stack pointer constant
        MtrExceptData = 3'd3,
        MtrPc         = 3'd4
    } memToReg_t;

    typedef enum logic [1:0] {
        RdRt = 2'd0,
        RdRd = 2'd1,
        RdRa = 2'd2,            // $31
        RdSp = 2'd3             // $29
    } regDest_t;

    typedef enum logic [2:0] {
        AddrPc          = 3'd0,
        AddrOverflowVec = 3'd1,
        AddrInvalidVec  = 3'd3
    } srcAddr_t;

    typedef enum logic [2:0] {
        SizeWord       = 3'd4,
        SizeExceptByte = 3'd6   // Byte read of the handler address
    } sizeMode_t;

    typedef enum logic [2:0] {
        SrcBReg      = 3'd0,
        SrcBFour     = 3'd1,
        SrcBImm      = 3'd2,
        SrcBImmShift = 3'd3     // Immediate shifted left by two
    } aluSrcB_t;

endpackage

`default_nettype wire

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
    import ctrlPkg::*, datapathPkg::*;
(
    input  wire logic [OpcodeWidth-1:0] opcode,
    input  wire logic [OpcodeWidth-1:0] funct,
    output instrClass_t                 instrClass
);

    localparam logic [OpcodeWidth-1:0] OpRType = 6'h00;
    localparam logic [OpcodeWidth-1:0] OpJ     = 6'h02;
    localparam logic [OpcodeWidth-1:0] OpJal   = 6'h03;
    localparam logic [OpcodeWidth-1:0] OpBeq   = 6'h04;
    localparam logic [OpcodeWidth-1:0] OpBne   = 6'h05;
    localparam logic [OpcodeWidth-1:0] OpBle   = 6'h06;
    localparam logic [OpcodeWidth-1:0] OpBgt   = 6'h07;
    localparam logic [OpcodeWidth-1:0] OpAddi  = 6'h08;
    localparam logic [OpcodeWidth-1:0] OpAddiu = 6'h09;
    localparam logic [OpcodeWidth-1:0] OpSlti  = 6'h0a;
    localparam logic [OpcodeWidth-1:0] OpLw    = 6'h23;
    localparam logic [OpcodeWidth-1:0] OpSw    = 6'h2b;

    localparam logic [OpcodeWidth-1:0] FnJr    = 6'h08;
    localparam logic [OpcodeWidth-1:0] FnAdd   = 6'h20;
    localparam logic [OpcodeWidth-1:0] FnSub   = 6'h22;
    localparam logic [OpcodeWidth-1:0] FnAnd   = 6'h24;
    localparam logic [OpcodeWidth-1:0] FnOr    = 6'h25;
    localparam logic [OpcodeWidth-1:0] FnSlt   = 6'h2a;

    always_comb
    begin
        instrClass = ClsInvalid;                // Shifts, mult, div land here too
        case (opcode)
            OpRType:
            begin
                case (funct)
                    FnAdd:   instrClass = ClsAdd;
                    FnSub:   instrClass = ClsSub;
                    FnAnd:   instrClass = ClsAnd;
                    FnOr:    instrClass = ClsOr;
                    FnSlt:   instrClass = ClsSlt;
                    FnJr:    instrClass = ClsJr;
                    default: instrClass = ClsInvalid;
                endcase
            end
            OpAddi:  instrClass = ClsAddi;
            OpAddiu: instrClass = ClsAddiu;
            OpSlti:  instrClass = ClsSlti;
            OpBeq:   instrClass = ClsBeq;
            OpBne:   instrClass = ClsBne;
            OpBle:   instrClass = ClsBle;
            OpBgt:   instrClass = ClsBgt;
            OpLw:    instrClass = ClsLw;
            OpSw:    instrClass = ClsSw;
            OpJ:     instrClass = ClsJ;
            OpJal:   instrClass = ClsJal;
            default: instrClass = ClsInvalid;
        endcase
    end

endmodule

`default_nettype wire

// ==== controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
    import ctrlPkg::*;
#(
    parameter int MemWaitCycles    = 2,
    parameter int ExceptWaitCycles = 6
)
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  instrClass_t instrClass,
    input  wire logic  overflowFlag,
    output ctrlState_t state
);

    localparam int MaxWait    = (MemWaitCycles > ExceptWaitCycles) ?
                                MemWaitCycles : ExceptWaitCycles;
    localparam int CountWidth = $clog2(MaxWait + 1);

    ctrlState_t            nextState;
    ctrlState_t            successor;
    logic [CountWidth-1:0] waitCount;    // Cycles left in the current state
    logic                  waitDone;
    logic                  overflowJump;
    logic                  changeState;

    // Counter value loaded on entry, one less than the dwell
    function automatic logic [CountWidth-1:0] dwellLoad(input ctrlState_t s);
        logic [CountWidth-1:0] load;
        case (s)
            ResetInit, Fetch1, ReadMem, LoadWord:
                load = CountWidth'(MemWaitCycles - 1);
            InvalidOp, Overflow:
                load = CountWidth'(ExceptWaitCycles - 1);
            default:
                load = '0;                          // Single cycle, Jal included
        endcase
        return load;
    endfunction

    always_comb
    begin
        waitDone     = (waitCount == '0);
        overflowJump = overflowFlag && !(state inside {ResetInit, Overflow, Exception});
        changeState  = overflowJump || waitDone;

        successor = Fetch1;                         // Every path returns to fetch
        case (state)
            ResetInit:     successor = Fetch1;
            Fetch1:        successor = Fetch2;
            Fetch2:        successor = Decode;
            Decode:
            begin
                case (instrClass)
                    ClsAdd, ClsSub, ClsAnd, ClsOr, ClsSlt:
                        successor = AluR;
                    ClsAddi, ClsAddiu, ClsSlti:
                        successor = AluI;
                    ClsJr:
                        successor = Jr;
                    ClsBeq, ClsBne, ClsBle, ClsBgt:
                        successor = BranchCalc;
                    ClsLw, ClsSw:
                        successor = MemCalc;
                    ClsJ:
                        successor = Jump;
                    ClsJal:
                        successor = Jal;
                    default:
                        successor = InvalidOp;
                endcase
            end
            AluR:          successor = WriteRd;
            AluI:          successor = WriteRt;
            Jr:            successor = SavePc;
            BranchCalc:    successor = BranchCompare;
            BranchCompare: successor = BranchCommit;
            MemCalc:       successor = (instrClass == ClsSw) ? StoreWord : ReadMem;
            ReadMem:       successor = LoadWord;
            InvalidOp:     successor = Exception;
            Overflow:      successor = Exception;
            default:       successor = Fetch1;
        endcase

        nextState = overflowJump ? Overflow : successor;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= ResetInit;
            waitCount <= dwellLoad(ResetInit);
        end
        else if (changeState)
        begin
            state     <= nextState;
            waitCount <= dwellLoad(nextState);   // Overflow restarts the count
        end
        else
        begin
            waitCount <= waitCount - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== datapathControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapathControl
    import ctrlPkg::*, datapathPkg::*;
(
    input  ctrlState_t  state,
    input  instrClass_t instrClass,
    output logic        PCWriteCond,
    output logic        PCWrite,
    output logic        IorD,
    output srcAddr_t    SrcAddr,
    output logic        WR,
    output memToReg_t   MemToReg,
    output sizeMode_t   SizeHandler,
    output logic        IRWrite,
    output logic        EPCWrite,
    output regDest_t    RegDest,
    output logic        RegWrite,
    output logic        ALUSrcA,
    output aluSrcB_t    ALUSrcB,
    output aluOp_t      ControlType,
    output pcSource_t   PCSource
);

    // ALU code per class, classes never overlap between states
    function automatic aluOp_t aluCodeFor(input instrClass_t cls);
        aluOp_t op;
        case (cls)
            ClsAdd, ClsAddi: op = AluAddOv;
            ClsAddiu:        op = AluAddNoOv;
            ClsSub:          op = AluSub;
            ClsAnd:          op = AluAnd;
            ClsOr:           op = AluOr;
            ClsSlt, ClsSlti: op = AluCmp;
            ClsBeq:          op = AluEq;
            ClsBne:          op = AluNe;
            ClsBle:          op = AluLe;
            ClsBgt:          op = AluGt;
            default:         op = AluLoad;
        endcase
        return op;
    endfunction

    always_comb
    begin
        PCWriteCond = 1'b0;
        PCWrite     = 1'b0;
        IorD        = 1'b0;
        SrcAddr     = AddrPc;
        WR          = 1'b0;
        MemToReg    = MtrAluOut;
        SizeHandler = sizeMode_t'(3'd0);
        IRWrite     = 1'b0;
        EPCWrite    = 1'b0;
        RegDest     = RdRt;
        RegWrite    = 1'b0;
        ALUSrcA     = 1'b0;
        ALUSrcB     = SrcBReg;
        ControlType = AluLoad;
        PCSource    = PcAluOut;

        case (state)
            ResetInit:
            begin
                RegWrite = 1'b1;                    // Load $sp
                RegDest  = RdSp;
                MemToReg = MtrStackInit;
            end
            Fetch2:
            begin
                IRWrite     = 1'b1;
                ALUSrcB     = SrcBFour;             // PC + 4
                ControlType = AluAddOv;
            end
            Decode:
                PCWrite = 1'b1;
            AluR:
            begin
                ALUSrcA     = 1'b1;
                ALUSrcB     = SrcBReg;
                ControlType = aluCodeFor(instrClass);
            end
            AluI:
            begin
                ALUSrcA     = 1'b1;
                ALUSrcB     = SrcBImm;
                ControlType = aluCodeFor(instrClass);
            end
            WriteRd:
            begin
                RegWrite = 1'b1;
                RegDest  = RdRd;
            end
            WriteRt:
            begin
                RegWrite = 1'b1;
                RegDest  = RdRt;
            end
            Jr:
            begin
                ALUSrcA     = 1'b1;
                ControlType = AluLoad;              // rs straight through
                PCSource    = PcAluResult;
                PCWrite     = 1'b1;
            end
            SavePc:
            begin
                PCSource = PcAluResult;
                PCWrite  = 1'b1;
            end
            BranchCalc:
            begin
                ALUSrcB     = SrcBImmShift;
                ControlType = AluAddOv;
            end
            BranchCompare:
            begin
                ALUSrcA     = 1'b1;
                PCWriteCond = 1'b1;                 // Target taken from ALUOut
                ControlType = aluCodeFor(instrClass);
            end
            BranchCommit:
                ALUSrcA = 1'b1;
            MemCalc, ReadMem:
            begin
                IorD        = (state == ReadMem);
                ALUSrcA     = 1'b1;
                ALUSrcB     = SrcBImm;
                ControlType = AluAddOv;
            end
            LoadWord:
            begin
                IorD        = 1'b1;
                SizeHandler = SizeWord;
                MemToReg    = MtrMemData;
                RegDest     = RdRt;
                RegWrite    = 1'b1;
            end
            StoreWord:
            begin
                IorD        = 1'b1;
                SizeHandler = SizeWord;
                WR          = 1'b1;
                ALUSrcA     = 1'b1;                 // Keep the address stable
                ALUSrcB     = SrcBImm;
                ControlType = AluAddOv;
            end
            Jump, Jal:
            begin
                PCSource = PcJumpTarget;
                PCWrite  = 1'b1;
                RegWrite = (state == Jal);          // Return address to $ra
                RegDest  = (state == Jal) ? RdRa : RdRt;
                MemToReg = (state == Jal) ? MtrPc : MtrAluOut;
            end
            InvalidOp, Overflow:
            begin
                PCWrite     = 1'b1;
                EPCWrite    = 1'b1;
                PCSource    = PcExceptVector;
                SizeHandler = SizeExceptByte;
                RegDest     = RdSp;
                MemToReg    = MtrMemData;
                SrcAddr     = (state == Overflow) ? AddrOverflowVec : AddrInvalidVec;
            end
            Exception:
            begin
                PCSource    = PcExceptVector;
                SizeHandler = SizeExceptByte;
                RegDest     = RdSp;
                MemToReg    = MtrExceptData;
            end
            default:
            begin
                PCSource = PcAluOut;                // Fetch1 uses the defaults
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit
    import ctrlPkg::*, datapathPkg::*;
#(
    parameter int MemWaitCycles    = 2,     // Memory latency
    parameter int ExceptWaitCycles = 6      // Exception entry dwell
)
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [OpcodeWidth-1:0] opcode,
    input  wire logic [OpcodeWidth-1:0] funct,
    input  wire logic                   overflowFlag,
    output logic                        PCWriteCond,
    output logic                        PCWrite,
    output logic                        IorD,
    output srcAddr_t                    SrcAddr,
    output logic                        WR,
    output memToReg_t                   MemToReg,
    output sizeMode_t                   SizeHandler,
    output logic                        IRWrite,
    output logic                        EPCWrite,
    output regDest_t                    RegDest,
    output logic                        RegWrite,
    output logic                        ALUSrcA,
    output aluSrcB_t                    ALUSrcB,
    output aluOp_t                      ControlType,
    output pcSource_t                   PCSource
);

    instrClass_t instrClass;
    ctrlState_t  state;

    instrDecoder decoder_i (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    controlSequencer #(
        .MemWaitCycles    (MemWaitCycles),
        .ExceptWaitCycles (ExceptWaitCycles)
    ) sequencer_i (
        .clk          (clk),
        .reset        (reset),
        .instrClass   (instrClass),
        .overflowFlag (overflowFlag),
        .state        (state)
    );

    datapathControl outputs_i (
        .state       (state),
        .instrClass  (instrClass),
        .PCWriteCond (PCWriteCond),
        .PCWrite     (PCWrite),
        .IorD        (IorD),
        .SrcAddr     (SrcAddr),
        .WR          (WR),
        .MemToReg    (MemToReg),
        .SizeHandler (SizeHandler),
        .IRWrite     (IRWrite),
        .EPCWrite    (EPCWrite),
        .RegDest     (RegDest),
        .RegWrite    (RegWrite),
        .ALUSrcA     (ALUSrcA),
        .ALUSrcB     (ALUSrcB),
        .ControlType (ControlType),
        .PCSource    (PCSource)
    );

endmodule

`default_nettype wire

// ==== tb_controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_controlUnit
    import ctrlPkg::*, datapathPkg::*;
();

    localparam int HalfPeriod     = 20;     // 40 ns clock
    localparam int ResetCycles    = 10;
    localparam int MaxInstrCycles = 40;     // Per instruction, before giving up
    localparam int MarginCycles   = 20;

    logic                   clk;
    logic                   reset;
    logic [OpcodeWidth-1:0] opcode;
    logic [OpcodeWidth-1:0] funct;
    logic                   overflowFlag;
    logic                   PCWriteCond;
    logic                   PCWrite;
    logic                   IorD;
    srcAddr_t               SrcAddr;
    logic                   WR;
    memToReg_t              MemToReg;
    sizeMode_t              SizeHandler;
    logic                   IRWrite;
    logic                   EPCWrite;
    regDest_t               RegDest;
    logic                   RegWrite;
    logic                   ALUSrcA;
    aluSrcB_t               ALUSrcB;
    aluOp_t                 ControlType;
    pcSource_t              PCSource;

    int memWait;
    int exceptWait;
    int checkCount    = 0;
    int mismatchCount = 0;
    int failCount     = 0;
    int pcwcCycles;                         // Pulse widths seen in the last instruction
    int wrCycles;
    int epcCycles;
    ctrlState_t path[$];                    // Expected state per cycle

    controlUnit dut_i (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .funct        (funct),
        .overflowFlag (overflowFlag),
        .PCWriteCond  (PCWriteCond),
        .PCWrite      (PCWrite),
        .IorD         (IorD),
        .SrcAddr      (SrcAddr),
        .WR           (WR),
        .MemToReg     (MemToReg),
        .SizeHandler  (SizeHandler),
        .IRWrite      (IRWrite),
        .EPCWrite     (EPCWrite),
        .RegDest      (RegDest),
        .RegWrite     (RegWrite),
        .ALUSrcA      (ALUSrcA),
        .ALUSrcB      (ALUSrcB),
        .ControlType  (ControlType),
        .PCSource     (PCSource)
    );

    initial
    begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    function automatic int dwellOf(input ctrlState_t s);
        case (s)
            ResetInit, Fetch1, ReadMem, LoadWord: return memWait;
            InvalidOp, Overflow:                  return exceptWait;
            default:                              return 1;
        endcase
    endfunction

    task automatic addState(input ctrlState_t s);
        repeat (dwellOf(s)) path.push_back(s);
    endtask

    // States from Decode up to the next IR load
    task automatic buildPath(input instrClass_t cls, input bit ovf);
        path.delete();
        addState(Decode);
        case (cls)
            ClsAdd, ClsSub, ClsAnd, ClsOr, ClsSlt:
            begin
                addState(AluR);
                if (ovf)
                begin
                    addState(Overflow);
                    addState(Exception);
                end
                else
                begin
                    addState(WriteRd);
                end
            end
            ClsAddi, ClsAddiu, ClsSlti:
            begin
                addState(AluI);
                addState(WriteRt);
            end
            ClsJr:
            begin
                addState(Jr);
                addState(SavePc);
            end
            ClsBeq, ClsBne, ClsBle, ClsBgt:
            begin
                addState(BranchCalc);
                addState(BranchCompare);
                addState(BranchCommit);
            end
            ClsLw:
            begin
                addState(MemCalc);
                addState(ReadMem);
                addState(LoadWord);
            end
            ClsSw:
            begin
                addState(MemCalc);
                addState(StoreWord);
            end
            ClsJ:    addState(Jump);
            ClsJal:  addState(Jal);
            default:
            begin
                addState(InvalidOp);
                addState(Exception);
            end
        endcase
        addState(Fetch1);
        addState(Fetch2);
    endtask

    task automatic compareField(input string name, input ctrlState_t s, input int got,
                                input int want);
        checkCount++;
        if (got != want)
        begin
            mismatchCount++;
            $display("Mismatch %s in %s: got %0h, expected %0h", name, s.name(), got, want);
        end
    endtask

    // Expected outputs of one state, unlisted outputs stay at zero
    task automatic verifyOutputs(input ctrlState_t s, input aluOp_t alu);
        logic       ePcwc, ePcw, eIorD, eWr, eIr, eEpc, eRegW, eSrcA;
        logic [2:0] eAddr, eMtr, eSize, eSrcB, ePcSrc;
        logic [1:0] eDest;
        logic [4:0] eAlu;
        {ePcwc, ePcw, eIorD, eWr, eIr, eEpc, eRegW, eSrcA} = '0;
        {eAddr, eMtr, eSize, eSrcB, eDest, eAlu} = '0;
        ePcSrc = PcAluOut;
        case (s)
            ResetInit:     {eRegW, eDest, eMtr} = {1'b1, RdSp, MtrStackInit};
            Fetch2:        {eIr, eSrcB, eAlu} = {1'b1, SrcBFour, AluAddOv};
            Decode:        ePcw = 1'b1;
            AluR:          {eSrcA, eSrcB, eAlu} = {1'b1, SrcBReg, alu};
            AluI:          {eSrcA, eSrcB, eAlu} = {1'b1, SrcBImm, alu};
            WriteRd:       {eRegW, eDest} = {1'b1, RdRd};
            WriteRt:       {eRegW, eDest} = {1'b1, RdRt};
            Jr:            {eSrcA, eAlu, ePcSrc, ePcw} = {1'b1, AluLoad, PcAluResult, 1'b1};
            SavePc:        {ePcSrc, ePcw} = {PcAluResult, 1'b1};
            BranchCalc:    {eSrcB, eAlu} = {SrcBImmShift, AluAddOv};
            BranchCompare: {eSrcA, ePcwc, eAlu} = {1'b1, 1'b1, alu};
            BranchCommit:  eSrcA = 1'b1;
            MemCalc:       {eSrcA, eSrcB, eAlu} = {1'b1, SrcBImm, AluAddOv};
            ReadMem:       {eIorD, eSrcA, eSrcB, eAlu} = {1'b1, 1'b1, SrcBImm, AluAddOv};
            LoadWord:      {eIorD, eSize, eMtr, eDest, eRegW} =
                               {1'b1, SizeWord, MtrMemData, RdRt, 1'b1};
            StoreWord:     {eIorD, eSize, eWr, eSrcA, eSrcB, eAlu} =
                               {1'b1, SizeWord, 1'b1, 1'b1, SrcBImm, AluAddOv};
            Jump:          {ePcSrc, ePcw} = {PcJumpTarget, 1'b1};
            Jal:           {ePcSrc, ePcw, eRegW, eDest, eMtr} =
                               {PcJumpTarget, 1'b1, 1'b1, RdRa, MtrPc};
            InvalidOp:
            begin
                {ePcw, eEpc, ePcSrc, eSize} = {1'b1, 1'b1, PcExceptVector, SizeExceptByte};
                {eDest, eMtr, eAddr} = {RdSp, MtrMemData, AddrInvalidVec};
            end
            Overflow:
            begin
                {ePcw, eEpc, ePcSrc, eSize} = {1'b1, 1'b1, PcExceptVector, SizeExceptByte};
                {eDest, eMtr, eAddr} = {RdSp, MtrMemData, AddrOverflowVec};
            end
            Exception:     {ePcSrc, eSize, eDest, eMtr} =
                               {PcExceptVector, SizeExceptByte, RdSp, MtrExceptData};
            default:       ePcSrc = PcAluOut;         // Fetch1
        endcase
        compareField("PCWriteCond", s, int'(PCWriteCond), int'(ePcwc));
        compareField("PCWrite", s, int'(PCWrite), int'(ePcw));
        compareField("IorD", s, int'(IorD), int'(eIorD));
        compareField("SrcAddr", s, int'(SrcAddr), int'(eAddr));
        compareField("WR", s, int'(WR), int'(eWr));
        compareField("MemToReg", s, int'(MemToReg), int'(eMtr));
        compareField("SizeHandler", s, int'(SizeHandler), int'(eSize));
        compareField("IRWrite", s, int'(IRWrite), int'(eIr));
        compareField("EPCWrite", s, int'(EPCWrite), int'(eEpc));
        compareField("RegDest", s, int'(RegDest), int'(eDest));
        compareField("RegWrite", s, int'(RegWrite), int'(eRegW));
        compareField("ALUSrcA", s, int'(ALUSrcA), int'(eSrcA));
        compareField("ALUSrcB", s, int'(ALUSrcB), int'(eSrcB));
        compareField("ControlType", s, int'(ControlType), int'(eAlu));
        compareField("PCSource", s, int'(PCSource), int'(ePcSrc));
    endtask

    // Walks the expected path one cycle at a time until IRWrite comes back
    task automatic followPath(input aluOp_t alu, input bit ovf, output int len);
        int idx;
        bit seen;
        idx = 0;
        seen = 1'b0;
        pcwcCycles = 0;
        wrCycles = 0;
        epcCycles = 0;
        while (!seen && idx < MaxInstrCycles)
        begin
            @(negedge clk);                             // Outputs settled mid cycle
            if (idx < path.size())
            begin
                verifyOutputs(path[idx], alu);
            end
            else if (idx == path.size())
            begin
                failCount++;
                $display("Controller stayed busy past the expected %0d cycles", path.size());
            end
            if (PCWriteCond) pcwcCycles++;
            if (WR) wrCycles++;
            if (EPCWrite) epcCycles++;
            seen = IRWrite;
            idx++;
            if (!seen)
            begin
                @(posedge clk);
                overflowFlag <= ovf && (idx == 1);      // High for the AluR cycle only
            end
        end
        if (!seen)
        begin
            failCount++;
            $display("IRWrite did not return within %0d cycles", MaxInstrCycles);
        end
        len = idx;
    endtask

    task automatic runInstr(input string name, input logic [OpcodeWidth-1:0] op,
                            input logic [OpcodeWidth-1:0] fn, input instrClass_t cls,
                            input aluOp_t alu, input bit ovf, input int expLen);
        int len;
        @(posedge clk);                                 // Entering Decode
        opcode <= op;
        funct  <= fn;
        buildPath(cls, ovf);
        followPath(alu, ovf, len);
        if (len != expLen)
        begin
            failCount++;
            $display("%s took %0d cycles from fetch to fetch instead of %0d", name, len, expLen);
        end
    endtask

    task automatic validatePulse(input string what, input string instr, input int seen,
                                 input int want);
        if (seen != want)
        begin
            failCount++;
            $display("%s was high for %0d cycles on %s instead of %0d", what, seen, instr, want);
        end
    endtask

    task automatic resetSequence();
        int len;
        repeat (ResetCycles - 1) @(posedge clk);
        @(negedge clk);
        verifyOutputs(ResetInit, AluLoad);              // Held while reset is high
        @(posedge clk);
        reset <= 1'b0;
        path.delete();
        addState(ResetInit);
        addState(Fetch1);
        addState(Fetch2);
        followPath(AluLoad, 1'b0, len);
        if (len != 2 * memWait + 1)
        begin
            failCount++;
            $display("First IRWrite came %0d cycles after reset instead of %0d",
                     len, 2 * memWait + 1);
        end
    endtask

    task automatic aluOps();
        runInstr("add", 6'h00, 6'h20, ClsAdd, AluAddOv, 1'b0, memWait + 4);
        runInstr("sub", 6'h00, 6'h22, ClsSub, AluSub, 1'b0, memWait + 4);
        runInstr("and", 6'h00, 6'h24, ClsAnd, AluAnd, 1'b0, memWait + 4);
        runInstr("or", 6'h00, 6'h25, ClsOr, AluOr, 1'b0, memWait + 4);
        runInstr("slt", 6'h00, 6'h2a, ClsSlt, AluCmp, 1'b0, memWait + 4);
        runInstr("addi", 6'h08, 6'h00, ClsAddi, AluAddOv, 1'b0, memWait + 4);
        runInstr("addiu", 6'h09, 6'h00, ClsAddiu, AluAddNoOv, 1'b0, memWait + 4);
        runInstr("slti", 6'h0a, 6'h00, ClsSlti, AluCmp, 1'b0, memWait + 4);
    endtask

    task automatic branchOps();
        runInstr("beq", 6'h04, 6'h00, ClsBeq, AluEq, 1'b0, memWait + 5);
        validatePulse("PCWriteCond", "beq", pcwcCycles, 1);
        runInstr("bne", 6'h05, 6'h00, ClsBne, AluNe, 1'b0, memWait + 5);
        validatePulse("PCWriteCond", "bne", pcwcCycles, 1);
        runInstr("ble", 6'h06, 6'h00, ClsBle, AluLe, 1'b0, memWait + 5);
        validatePulse("PCWriteCond", "ble", pcwcCycles, 1);
        runInstr("bgt", 6'h07, 6'h00, ClsBgt, AluGt, 1'b0, memWait + 5);
        validatePulse("PCWriteCond", "bgt", pcwcCycles, 1);
    endtask

    task automatic loadStore();
        runInstr("lw", 6'h23, 6'h00, ClsLw, AluLoad, 1'b0, 3 * memWait + 3);
        runInstr("sw", 6'h2b, 6'h00, ClsSw, AluLoad, 1'b0, memWait + 4);
        validatePulse("WR", "sw", wrCycles, 1);
    endtask

    task automatic jumpOps();
        runInstr("j", 6'h02, 6'h00, ClsJ, AluLoad, 1'b0, memWait + 3);
        runInstr("jal", 6'h03, 6'h00, ClsJal, AluLoad, 1'b0, memWait + 3);
        runInstr("jr", 6'h00, 6'h08, ClsJr, AluLoad, 1'b0, memWait + 4);
    endtask

    task automatic exceptionEntry();
        runInstr("opcode 3f", 6'h3f, 6'h00, ClsInvalid, AluLoad, 1'b0, memWait + exceptWait + 3);
        validatePulse("EPCWrite", "opcode 3f", epcCycles, exceptWait);
        runInstr("sll", 6'h00, 6'h00, ClsInvalid, AluLoad, 1'b0, memWait + exceptWait + 3);
        validatePulse("EPCWrite", "sll", epcCycles, exceptWait);
        runInstr("div", 6'h00, 6'h1a, ClsInvalid, AluLoad, 1'b0, memWait + exceptWait + 3);
        validatePulse("EPCWrite", "div", epcCycles, exceptWait);
        runInstr("add overflow", 6'h00, 6'h20, ClsAdd, AluAddOv, 1'b1,
                 memWait + exceptWait + 4);
        validatePulse("EPCWrite", "add overflow", epcCycles, exceptWait);
    endtask

    initial
    begin
        reset        = 1'b1;
        opcode       = '0;
        funct        = '0;
        overflowFlag = 1'b0;
        memWait      = dut_i.MemWaitCycles;
        exceptWait   = dut_i.ExceptWaitCycles;

        resetSequence();
        aluOps();
        branchOps();
        loadStore();
        jumpOps();
        exceptionEntry();

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checkCount, mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Sum of all instruction lengths plus reset and a margin
    initial
    begin : watchdog
        int m;
        int e;
        int limitCycles;
        m = dut_i.MemWaitCycles;
        e = dut_i.ExceptWaitCycles;
        limitCycles = ResetCycles + (2 * m + 1) + 8 * (m + 4) + 4 * (m + 5)
                      + (3 * m + 3) + (m + 4) + 2 * (m + 3) + (m + 4)
                      + 3 * (m + e + 3) + (m + e + 4) + MarginCycles;
        repeat (limitCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the controller stopped fetching",
                 limitCycles);
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checkCount, mismatchCount, failCount + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
ctrlPkg.sv
datapathPkg.sv
instrDecoder.sv
controlSequencer.sv
datapathControl.sv
controlUnit.sv
tb_controlUnit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_controlUnit
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
